/* rtl/feature_pkg.sv */
package feature_pkg;

	// feature word and bank geometry.
	localparam int DATA_W     = 16;
	localparam int ADDR_W     = 7;
	localparam int BANK_DEPTH = 128;

	// sweep pattern of taps within a channel.
	localparam int TAP_COUNT  = 3;
	localparam int TAP_STRIDE = 2;

	// channels within a window.
	localparam int CHAN_COUNT = 2;
	localparam int CHAN_STEP  = 1;

	// windows within one sweep.
	localparam int WIN_STEP   = 5;
	localparam int WIN_COUNT  = 16;

	// counter widths for the sweep.
	localparam int TAP_W  = $clog2(TAP_COUNT);
	localparam int CHAN_W = (CHAN_COUNT > 1) ? $clog2(CHAN_COUNT) : 1;
	localparam int WIN_W  = $clog2(WIN_COUNT);

	// address in to data out of a feature bank.
	localparam int RD_LATENCY = 3;

endpackage

/* rtl/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram (
	input  logic                             clk,
	input  logic                             i_we,
	input  logic [feature_pkg::ADDR_W-1:0]   i_waddr,
	input  logic [feature_pkg::DATA_W-1:0]   i_wdata,
	input  logic [feature_pkg::ADDR_W-1:0]   i_raddr,
	output logic [feature_pkg::DATA_W-1:0]   o_rdata
);

	logic [feature_pkg::DATA_W-1:0] mem [feature_pkg::BANK_DEPTH];

	// write port.
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// the read port registers on every edge.
	always_ff @(posedge clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

/* rtl/feature_bank.sv */
`timescale 1ns/1ps

module feature_bank (
	input  logic                             clk,
	input  logic                             i_we,
	input  logic [feature_pkg::ADDR_W-1:0]   i_waddr,
	input  logic [feature_pkg::DATA_W-1:0]   i_wdata,
	input  logic [feature_pkg::ADDR_W-1:0]   i_raddr,
	output logic [feature_pkg::DATA_W-1:0]   o_rdata
);

	logic [feature_pkg::ADDR_W-1:0] raddr_q;
	logic [feature_pkg::DATA_W-1:0] ram_rdata;
	logic [feature_pkg::DATA_W-1:0] rdata_q;

	// first stage registers the read address.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
	end

	// second stage is the ram's own output register.
	dual_port_ram u_dual_port_ram (
		.clk     (clk),
		.i_we    (i_we),
		.i_waddr (i_waddr),
		.i_wdata (i_wdata),
		.i_raddr (raddr_q),
		.o_rdata (ram_rdata)
	);

	// third stage.
	always_ff @(posedge clk) begin
		rdata_q <= ram_rdata;
	end

	assign o_rdata = rdata_q;

endmodule

/* rtl/window_addr_gen.sv */
`timescale 1ns/1ps

module window_addr_gen (
	input  logic                             clk,
	input  logic                             i_reset,
	input  logic                             i_start,
	output logic [feature_pkg::ADDR_W-1:0]   o_raddr,
	output logic                             o_rd_en,
	output logic                             o_last
);

	localparam int AW = feature_pkg::ADDR_W;

	logic [feature_pkg::TAP_W-1:0]  tap_q;
	logic [feature_pkg::CHAN_W-1:0] chan_q;
	logic [feature_pkg::WIN_W-1:0]  win_q;
	logic [AW-1:0]                  base_q;
	logic [AW-1:0]                  offset_q;
	logic                           tap_end;
	logic                           chan_end;
	logic                           win_end;

	assign tap_end  = (tap_q == feature_pkg::TAP_W'(feature_pkg::TAP_COUNT - 1));
	assign chan_end = (chan_q == feature_pkg::CHAN_W'(feature_pkg::CHAN_COUNT - 1));
	assign win_end  = (win_q == feature_pkg::WIN_W'(feature_pkg::WIN_COUNT - 1));

	// counters always describe the address currently on o_raddr.
	assign o_last = o_rd_en & tap_end & chan_end & win_end;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rd_en  <= 1'b0;
			o_raddr  <= '0;
			tap_q    <= '0;
			chan_q   <= '0;
			win_q    <= '0;
			base_q   <= '0;
			offset_q <= '0;
		end else if (!o_rd_en) begin
			if (i_start) begin
				o_rd_en  <= 1'b1;
				o_raddr  <= '0;
				tap_q    <= '0;
				chan_q   <= '0;
				win_q    <= '0;
				base_q   <= '0;
				offset_q <= '0;
			end
		end else if (!tap_end) begin
			// next tap in the same channel.
			tap_q    <= tap_q + 1'b1;
			offset_q <= offset_q + AW'(feature_pkg::TAP_STRIDE);
			o_raddr  <= base_q + offset_q + AW'(feature_pkg::TAP_STRIDE);
		end else if (!chan_end) begin
			// next channel.
			tap_q    <= '0;
			chan_q   <= chan_q + 1'b1;
			offset_q <= '0;
			base_q   <= base_q + AW'(feature_pkg::CHAN_STEP);
			o_raddr  <= base_q + AW'(feature_pkg::CHAN_STEP);
		end else begin
			// next window, or the end of the sweep.
			tap_q    <= '0;
			chan_q   <= '0;
			win_q    <= win_end ? '0 : win_q + 1'b1;
			offset_q <= '0;
			base_q   <= base_q + AW'(feature_pkg::WIN_STEP);
			o_raddr  <= base_q + AW'(feature_pkg::WIN_STEP);
			if (win_end) begin
				o_rd_en <= 1'b0;
			end
		end
	end

endmodule

/* rtl/ddr_load_counter.sv */
`timescale 1ns/1ps

module ddr_load_counter (
	input  logic                             clk,
	input  logic                             i_reset,
	input  logic                             i_ddr_valid,
	output logic [feature_pkg::ADDR_W-1:0]   o_waddr
);

	localparam logic [feature_pkg::ADDR_W-1:0] LAST_ADDR =
		feature_pkg::ADDR_W'(feature_pkg::BANK_DEPTH - 1);

	logic [feature_pkg::ADDR_W-1:0] waddr_q;

	// one step per ddr word, wrapping at the end of the bank.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			waddr_q <= '0;
		end else if (i_ddr_valid) begin
			if (waddr_q == LAST_ADDR) begin
				waddr_q <= '0;
			end else begin
				waddr_q <= waddr_q + 1'b1;
			end
		end
	end

	assign o_waddr = waddr_q;

endmodule

/* rtl/stream_buffer.sv */
`timescale 1ns/1ps

module stream_buffer (
	input  logic                             clk,
	input  logic                             i_reset,
	input  logic                             i_start,
	input  logic                             i_wen0,
	input  logic [feature_pkg::ADDR_W-1:0]   i_waddr0,
	input  logic [feature_pkg::DATA_W-1:0]   i_ddr,
	input  logic                             i_wen1,
	input  logic [feature_pkg::ADDR_W-1:0]   i_waddr1,
	input  logic [feature_pkg::DATA_W-1:0]   i_pool,
	input  logic [feature_pkg::DATA_W-1:0]   i_eltwise,
	input  logic                             i_eltwise_sel,
	output logic [feature_pkg::DATA_W-1:0]   o_feature_0,
	output logic [feature_pkg::DATA_W-1:0]   o_feature_1,
	output logic                             o_feature_valid,
	output logic                             o_done,
	output logic                             o_busy
);

	localparam int LAT = feature_pkg::RD_LATENCY;

	logic [feature_pkg::ADDR_W-1:0] rd_addr;
	logic                           rd_en;
	logic                           rd_last;
	logic                           start_ok;
	logic                           busy_q;
	logic [feature_pkg::DATA_W-1:0] b1_wdata;

	// bit 0 carries the read enable and bit 1 the last flag.
	logic [1:0] align_q [LAT];

	// a start is taken only while no sweep is in flight.
	assign start_ok = i_start & ~busy_q;

	window_addr_gen u_window_addr_gen (
		.clk     (clk),
		.i_reset (i_reset),
		.i_start (start_ok),
		.o_raddr (rd_addr),
		.o_rd_en (rd_en),
		.o_last  (rd_last)
	);

	feature_bank u_bank0 (
		.clk     (clk),
		.i_we    (i_wen0),
		.i_waddr (i_waddr0),
		.i_wdata (i_ddr),
		.i_raddr (rd_addr),
		.o_rdata (o_feature_0)
	);

	// bank 1 takes either the pooling or the element-wise result.
	assign b1_wdata = i_eltwise_sel ? i_eltwise : i_pool;

	feature_bank u_bank1 (
		.clk     (clk),
		.i_we    (i_wen1),
		.i_waddr (i_waddr1),
		.i_wdata (b1_wdata),
		.i_raddr (rd_addr),
		.o_rdata (o_feature_1)
	);

	// delay enable and last to line up with the bank outputs.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < LAT; i++) begin
				align_q[i] <= 2'b00;
			end
		end else begin
			align_q[0] <= {rd_last, rd_en};
			for (int i = 1; i < LAT; i++) begin
				align_q[i] <= align_q[i-1];
			end
		end
	end

	assign o_feature_valid = align_q[LAT-1][0];
	assign o_done          = align_q[LAT-1][1];

	// busy covers the sweep up to and including the done cycle.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy_q <= 1'b0;
		end else if (start_ok) begin
			busy_q <= 1'b1;
		end else if (o_done) begin
			busy_q <= 1'b0;
		end
	end

	assign o_busy = busy_q;

endmodule

/* rtl/feature_stream_top.sv */
`timescale 1ns/1ps

module feature_stream_top (
	input  logic                             clk,
	input  logic                             i_reset,
	input  logic                             i_ddr_valid,
	input  logic [feature_pkg::DATA_W-1:0]   i_ddr,
	input  logic                             i_wen1,
	input  logic [feature_pkg::ADDR_W-1:0]   i_waddr,
	input  logic [feature_pkg::DATA_W-1:0]   i_pool,
	input  logic [feature_pkg::DATA_W-1:0]   i_eltwise,
	input  logic                             i_eltwise_sel,
	input  logic                             i_start,
	output logic [feature_pkg::DATA_W-1:0]   o_feature_0,
	output logic [feature_pkg::DATA_W-1:0]   o_feature_1,
	output logic                             o_feature_valid,
	output logic                             o_done,
	output logic                             o_busy
);

	logic [feature_pkg::ADDR_W-1:0] ddr_waddr;

	// bank 0 write pointer.
	ddr_load_counter u_ddr_load_counter (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_ddr_valid (i_ddr_valid),
		.o_waddr     (ddr_waddr)
	);

	stream_buffer u_stream_buffer (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_start         (i_start),
		.i_wen0          (i_ddr_valid),
		.i_waddr0        (ddr_waddr),
		.i_ddr           (i_ddr),
		.i_wen1          (i_wen1),
		.i_waddr1        (i_waddr),
		.i_pool          (i_pool),
		.i_eltwise       (i_eltwise),
		.i_eltwise_sel   (i_eltwise_sel),
		.o_feature_0     (o_feature_0),
		.o_feature_1     (o_feature_1),
		.o_feature_valid (o_feature_valid),
		.o_done          (o_done),
		.o_busy          (o_busy)
	);

endmodule

/* test/feature_stream_checker.sv */
`timescale 1ns/1ps

module feature_stream_checker (
	input  logic                             clk,
	input  logic                             i_reset,
	input  logic                             i_ddr_valid,
	input  logic [feature_pkg::DATA_W-1:0]   i_ddr,
	input  logic                             i_wen1,
	input  logic [feature_pkg::ADDR_W-1:0]   i_waddr,
	input  logic [feature_pkg::DATA_W-1:0]   i_pool,
	input  logic [feature_pkg::DATA_W-1:0]   i_eltwise,
	input  logic                             i_eltwise_sel,
	input  logic                             i_start,
	input  logic [feature_pkg::DATA_W-1:0]   o_feature_0,
	input  logic [feature_pkg::DATA_W-1:0]   o_feature_1,
	input  logic                             o_feature_valid,
	input  logic                             o_done,
	input  logic                             o_busy
);

	localparam int LAT = feature_pkg::RD_LATENCY;
	localparam int SWEEP_LEN =
		feature_pkg::TAP_COUNT * feature_pkg::CHAN_COUNT * feature_pkg::WIN_COUNT;

	logic [feature_pkg::DATA_W-1:0] shadow0 [feature_pkg::BANK_DEPTH];
	logic [feature_pkg::DATA_W-1:0] shadow1 [feature_pkg::BANK_DEPTH];
	logic [feature_pkg::ADDR_W-1:0] load_ptr;
	logic [feature_pkg::ADDR_W-1:0] exp_addr;
	logic [feature_pkg::DATA_W-1:0] exp_f0;
	logic [feature_pkg::DATA_W-1:0] exp_f1;
	logic                           started;
	logic                           start_ok;
	logic                           in_sweep;
	int                             tap;
	int                             chan;
	int                             base;
	int                             offset;
	int                             idx;
	int                             fail_count = 0;

	assign start_ok = i_start & ~o_busy;
	assign exp_addr = feature_pkg::ADDR_W'(base + offset);
	assign exp_f0   = shadow0[exp_addr];
	assign exp_f1   = shadow1[exp_addr];

	// shadow copies of both banks.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			load_ptr <= '0;
		end else if (i_ddr_valid) begin
			shadow0[load_ptr] <= i_ddr;
			load_ptr          <= load_ptr + 1'b1;
		end
		if (!i_reset && i_wen1) begin
			shadow1[i_waddr] <= i_eltwise_sel ? i_eltwise : i_pool;
		end
	end

	// walk the window pattern one step per valid output pair.
	always_ff @(posedge clk) begin
		if (i_reset || start_ok) begin
			started <= start_ok;
			tap     <= 0;
			chan    <= 0;
			base    <= 0;
			offset  <= 0;
			idx     <= 0;
		end else if (o_feature_valid) begin
			idx <= idx + 1;
			if (tap != feature_pkg::TAP_COUNT - 1) begin
				tap    <= tap + 1;
				offset <= offset + feature_pkg::TAP_STRIDE;
			end else if (chan != feature_pkg::CHAN_COUNT - 1) begin
				tap    <= 0;
				chan   <= chan + 1;
				offset <= 0;
				base   <= base + feature_pkg::CHAN_STEP;
			end else begin
				tap    <= 0;
				chan   <= 0;
				offset <= 0;
				base   <= base + feature_pkg::WIN_STEP;
			end
		end
	end

	// a sweep is in flight from its accepted start through its last pair.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			in_sweep <= 1'b0;
		end else if (start_ok) begin
			in_sweep <= 1'b1;
		end else if (o_feature_valid && idx == SWEEP_LEN - 1) begin
			in_sweep <= 1'b0;
		end
	end

	idle_before_start: assert property (@(posedge clk) disable iff (i_reset)
		!started |-> (!o_feature_valid && !o_done && !o_busy))
	else begin
		fail_count++;
		$error("FAIL o_feature_valid/o_done/o_busy got %h/%h/%h before any start",
			$sampled(o_feature_valid), $sampled(o_done), $sampled(o_busy));
	end

	valid_after_start: assert property (@(posedge clk) disable iff (i_reset)
		start_ok |=> !o_feature_valid [*LAT] ##1 o_feature_valid)
	else begin
		fail_count++;
		$error("o_feature_valid did not rise read latency plus one cycles after i_start");
	end

	valid_run: assert property (@(posedge clk) disable iff (i_reset)
		(o_feature_valid && idx < SWEEP_LEN - 1) |=> o_feature_valid)
	else begin
		fail_count++;
		$error("o_feature_valid dropped after %0d cycles of the sweep", $sampled(idx) + 1);
	end

	valid_length: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid |-> idx < SWEEP_LEN)
	else begin
		fail_count++;
		$error("o_feature_valid stayed high beyond the end of the sweep");
	end

	done_on_last: assert property (@(posedge clk) disable iff (i_reset)
		(o_feature_valid || o_done) |-> (o_done == (o_feature_valid && idx == SWEEP_LEN - 1)))
	else begin
		fail_count++;
		$error("FAIL o_done got %h expected %h at pair %0d", $sampled(o_done),
			$sampled(o_feature_valid && idx == SWEEP_LEN - 1), $sampled(idx));
	end

	busy_track: assert property (@(posedge clk) disable iff (i_reset)
		o_busy == in_sweep)
	else begin
		fail_count++;
		$error("FAIL o_busy got %h expected %h", $sampled(o_busy), $sampled(in_sweep));
	end

	feature_0_data: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid |-> o_feature_0 == exp_f0)
	else begin
		fail_count++;
		$error("FAIL o_feature_0 got %h expected %h at address %h",
			$sampled(o_feature_0), $sampled(exp_f0), $sampled(exp_addr));
	end

	feature_1_data: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid |-> o_feature_1 == exp_f1)
	else begin
		fail_count++;
		$error("FAIL o_feature_1 got %h expected %h at address %h",
			$sampled(o_feature_1), $sampled(exp_f1), $sampled(exp_addr));
	end

endmodule

bind feature_stream_top feature_stream_checker u_checker (
	.clk             (clk),
	.i_reset         (i_reset),
	.i_ddr_valid     (i_ddr_valid),
	.i_ddr           (i_ddr),
	.i_wen1          (i_wen1),
	.i_waddr         (i_waddr),
	.i_pool          (i_pool),
	.i_eltwise       (i_eltwise),
	.i_eltwise_sel   (i_eltwise_sel),
	.i_start         (i_start),
	.o_feature_0     (o_feature_0),
	.o_feature_1     (o_feature_1),
	.o_feature_valid (o_feature_valid),
	.o_done          (o_done),
	.o_busy          (o_busy)
);

/* test/feature_stream_tb.sv */
`timescale 1ns/1ps

module feature_stream_tb;

	localparam int TIMEOUT = 400;

	logic                           clk;
	logic                           i_reset;
	logic                           i_ddr_valid;
	logic [feature_pkg::DATA_W-1:0] i_ddr;
	logic                           i_wen1;
	logic [feature_pkg::ADDR_W-1:0] i_waddr;
	logic [feature_pkg::DATA_W-1:0] i_pool;
	logic [feature_pkg::DATA_W-1:0] i_eltwise;
	logic                           i_eltwise_sel;
	logic                           i_start;
	logic [feature_pkg::DATA_W-1:0] o_feature_0;
	logic [feature_pkg::DATA_W-1:0] o_feature_1;
	logic                           o_feature_valid;
	logic                           o_done;
	logic                           o_busy;
	logic [31:0]                    rand_state;

	feature_stream_top feature_stream_top_i (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_ddr_valid     (i_ddr_valid),
		.i_ddr           (i_ddr),
		.i_wen1          (i_wen1),
		.i_waddr         (i_waddr),
		.i_pool          (i_pool),
		.i_eltwise       (i_eltwise),
		.i_eltwise_sel   (i_eltwise_sel),
		.i_start         (i_start),
		.o_feature_0     (o_feature_0),
		.o_feature_1     (o_feature_1),
		.o_feature_valid (o_feature_valid),
		.o_done          (o_done),
		.o_busy          (o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rand_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rand_state = x;
		return x;
	endfunction

	// inputs change 1 ns after the edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_ddr(input int count);
		for (int i = 0; i < count; i++) begin
			i_ddr_valid = 1'b1;
			i_ddr       = feature_pkg::DATA_W'(next_rand());
			next_cycle();
		end
		i_ddr_valid = 1'b0;
	endtask

	task automatic write_bank1(input logic [feature_pkg::ADDR_W-1:0] addr);
		logic [31:0] r;
		logic [31:0] s;
		r = next_rand();
		s = next_rand();
		i_wen1        = 1'b1;
		i_waddr       = addr;
		i_pool        = r[15:0];
		i_eltwise     = r[31:16];
		i_eltwise_sel = s[9];
		next_cycle();
		i_wen1 = 1'b0;
	endtask

	task automatic pulse_start();
		i_start = 1'b1;
		next_cycle();
		i_start = 1'b0;
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (o_done !== 1'b1 && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (o_done !== 1'b1) begin
			$display("Some tests failed");
			$fatal(1, "timeout while waiting for o_done");
		end
	endtask

	task automatic wait_for_idle();
		int cycles;
		cycles = 0;
		while (o_busy !== 1'b0 && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (o_busy !== 1'b0) begin
			$display("Some tests failed");
			$fatal(1, "timeout while waiting for o_busy to fall");
		end
	endtask

	// a second start in the middle of the sweep must be ignored.
	task automatic run_sweep(input bit extra_start);
		pulse_start();
		if (extra_start) begin
			repeat (10) next_cycle();
			pulse_start();
		end
		wait_for_done();
		wait_for_idle();
	endtask

	always @(feature_stream_top_i.u_checker.fail_count) begin
		if (feature_stream_top_i.u_checker.fail_count != 0) begin
			$display("Some tests failed");
			$fatal(1, "an assertion in the checker failed");
		end
	end

	initial begin
		rand_state    = 32'h896d1f6a;
		i_reset       = 1'b1;
		i_ddr_valid   = 1'b0;
		i_ddr         = '0;
		i_wen1        = 1'b0;
		i_waddr       = '0;
		i_pool        = '0;
		i_eltwise     = '0;
		i_eltwise_sel = 1'b0;
		i_start       = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		i_reset = 1'b0;
		repeat (6) next_cycle();

		// fill both banks, then overwrite some bank 1 words.
		load_ddr(feature_pkg::BANK_DEPTH);
		for (int a = 0; a < feature_pkg::BANK_DEPTH; a++) begin
			write_bank1(feature_pkg::ADDR_W'(a));
		end
		repeat (40) write_bank1(feature_pkg::ADDR_W'(next_rand()));
		run_sweep(1'b0);

		run_sweep(1'b1);
		repeat (3) next_cycle();
		run_sweep(1'b0);

		// pointer wraps, so the newest words replace the oldest.
		load_ddr(160);
		repeat (20) write_bank1(feature_pkg::ADDR_W'(next_rand()));
		run_sweep(1'b0);
		repeat (5) next_cycle();

		if (feature_stream_top_i.u_checker.fail_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "an assertion in the checker failed");
		end
	end

endmodule

/* feature_stream.f */
rtl/feature_pkg.sv
rtl/dual_port_ram.sv
rtl/feature_bank.sv
rtl/window_addr_gen.sv
rtl/ddr_load_counter.sv
rtl/stream_buffer.sv
rtl/feature_stream_top.sv
test/feature_stream_checker.sv
test/feature_stream_tb.sv
